// ==== design/configure_pkg.sv ====
package configure_pkg;

    // number of 64-bit words held by the SRAM.
    localparam int sram_depth_words = 65536;

    // clocks that each 16-bit beat holds the SRAM pins.
    localparam int beat_cycles = 3;

    localparam int mem_addr_width = 32;
    localparam int mem_data_width = 64;
    localparam int mem_strb_width = mem_data_width / 8;

    // the chip is one halfword wide, so a bus word takes several beats.
    localparam int halfword_width = 16;
    localparam int beats_per_word = mem_data_width / halfword_width;

    // halfword address on the chip pins, 18 bits for the default depth.
    localparam int sram_addr_width = $clog2(sram_depth_words * beats_per_word);

endpackage

// ==== design/wires_pkg.sv ====
package wires_pkg;

    import configure_pkg::*;

    // request side of the memory bus. a nonzero strobe marks a write.
    typedef struct packed {
        logic mem_valid;
        logic [mem_addr_width-1:0] mem_addr;
        logic [mem_data_width-1:0] mem_wdata;
        logic [mem_strb_width-1:0] mem_wstrb;
    } mem_in_type;

    // response side; error and rdata only mean something while ready is high.
    typedef struct packed {
        logic mem_ready;
        logic mem_error;
        logic [mem_data_width-1:0] mem_rdata;
    } mem_out_type;

    // what the controller puts on the chip. the data pins are split into
    // an output value and a drive enable, the input value comes back apart.
    typedef struct packed {
        logic ce_n;
        logic we_n;
        logic oe_n;
        logic ub_n;
        logic lb_n;
        logic [sram_addr_width-1:0] addr;
        logic [halfword_width-1:0] dq_out;
        logic dq_drive;
    } sram_pins_type;

    // one bus word, seen whole or as halfwords with beat 0 the lowest.
    typedef union packed {
        logic [mem_data_width-1:0] word;
        logic [beats_per_word-1:0][halfword_width-1:0] half;
    } mem_word_type;

endpackage

// ==== design/mem_arbiter.sv ====
module mem_arbiter (
    input logic clock,
    input logic reset,
    input wires_pkg::mem_in_type fetch_in,
    input wires_pkg::mem_in_type data_in,
    output wires_pkg::mem_out_type fetch_out,
    output wires_pkg::mem_out_type data_out,
    output wires_pkg::mem_in_type ctrl_in,
    input wires_pkg::mem_out_type ctrl_out
);

    typedef enum logic [1:0] {
        grant_none,
        grant_fetch,
        grant_data
    } grant_type;

    grant_type grant;
    grant_type grant_next;

    // the data port wins a tie. once taken, the grant stays with its port
    // until the controller answers.
    always_comb begin
        grant_next = grant;
        case (grant)
            grant_none: begin
                if (data_in.mem_valid) begin
                    grant_next = grant_data;
                end else if (fetch_in.mem_valid) begin
                    grant_next = grant_fetch;
                end
            end
            default: begin
                if (ctrl_out.mem_ready) begin
                    grant_next = grant_none;
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset == 0) begin
            grant <= grant_none;
        end else begin
            grant <= grant_next;
        end
    end

    // forward the granted request and send the answer back to that port.
    // the port without the grant sees a quiet bus.
    always_comb begin
        ctrl_in = '0;
        fetch_out = '0;
        data_out = '0;
        case (grant)
            grant_fetch: begin
                ctrl_in = fetch_in;
                fetch_out = ctrl_out;
            end
            grant_data: begin
                ctrl_in = data_in;
                data_out = ctrl_out;
            end
            default: begin
            end
        endcase
    end

    // an open access keeps its grant until the controller is ready.
    assert property (@(posedge clock) disable iff (reset == 0)
        (grant != grant_none && !ctrl_out.mem_ready) |=> grant == $past(grant));

    // the controller only answers a request that some port was granted.
    assert property (@(posedge clock) disable iff (reset == 0)
        ctrl_out.mem_ready |-> grant != grant_none);

endmodule

// ==== design/sram_ctrl.sv ====
module sram_ctrl #(
    parameter int beat_cycles = configure_pkg::beat_cycles
) (
    input logic clock,
    input logic reset,
    input wires_pkg::mem_in_type ctrl_in,
    output wires_pkg::mem_out_type ctrl_out,
    output wires_pkg::sram_pins_type sram_pins,
    input logic [configure_pkg::halfword_width-1:0] sram_dq_in
);

    import configure_pkg::*;
    import wires_pkg::*;

    localparam int count_width = (beat_cycles > 1) ? $clog2(beat_cycles) : 1;
    localparam int beat_width = $clog2(beats_per_word);
    localparam int index_width = sram_addr_width - beat_width;
    localparam int word_lsb = $clog2(mem_strb_width);

    localparam logic [count_width-1:0] last_count = count_width'(beat_cycles - 1);
    localparam logic [beat_width-1:0] last_beat = beat_width'(beats_per_word - 1);

    localparam sram_pins_type pins_idle = '{
        ce_n: 1'b1,
        we_n: 1'b1,
        oe_n: 1'b1,
        ub_n: 1'b1,
        lb_n: 1'b1,
        addr: '0,
        dq_out: '0,
        dq_drive: 1'b0
    };

    typedef enum logic [1:0] {
        state_idle,
        state_setup,
        state_beat
    } state_type;

    typedef struct packed {
        state_type state;
        logic [count_width-1:0] counter;
        logic [beat_width-1:0] beat;
        mem_word_type data;
        logic [mem_strb_width-1:0] strb;
        logic [mem_addr_width-1:0] addr;
        logic write;
        logic read;
        logic ready;
        logic error;
        sram_pins_type pins;
    } register_type;

    register_type r, rin, v;

    always_comb begin
        v = r;
        v.ready = 1'b0;
        v.error = 1'b0;

        case (r.state)
            state_idle: begin
                // the request is still held while ready is high.
                if (ctrl_in.mem_valid && !r.ready) begin
                    v.state = state_setup;
                    v.addr = ctrl_in.mem_addr;
                    v.data.word = ctrl_in.mem_wdata;
                    v.strb = ctrl_in.mem_wstrb;
                    v.write = |ctrl_in.mem_wstrb;
                    v.read = ~|ctrl_in.mem_wstrb;
                end
            end
            state_setup: begin
                if (r.addr[mem_addr_width-1:word_lsb] >= sram_depth_words) begin
                    v.state = state_idle;
                    v.ready = 1'b1;
                    v.error = 1'b1;
                end else begin
                    v.state = state_beat;
                    v.beat = '0;
                    v.counter = '0;
                end
            end
            state_beat: begin
                if (r.counter == last_count) begin
                    // the chip has had the whole beat to settle its output.
                    if (r.read) begin
                        v.data.half[r.beat] = sram_dq_in;
                    end
                    v.counter = '0;
                    if (r.beat == last_beat) begin
                        v.state = state_idle;
                        v.ready = 1'b1;
                    end else begin
                        v.beat = r.beat + 1'b1;
                    end
                end else begin
                    v.counter = r.counter + 1'b1;
                end
            end
            default: begin
                v.state = state_idle;
            end
        endcase

        v.pins.ce_n = 1'b1;
        v.pins.we_n = 1'b1;
        v.pins.oe_n = 1'b1;
        v.pins.ub_n = 1'b1;
        v.pins.lb_n = 1'b1;
        v.pins.dq_drive = 1'b0;

        if (v.state == state_beat) begin
            v.pins.ce_n = 1'b0;
            v.pins.addr = {v.addr[word_lsb +: index_width], v.beat};
            if (v.write) begin
                // we_n rises for the last clock of the beat, so the chip
                // latches while address and data are still stable.
                v.pins.we_n = (v.counter == last_count);
                v.pins.ub_n = ~v.strb[{v.beat, 1'b1}];
                v.pins.lb_n = ~v.strb[{v.beat, 1'b0}];
                v.pins.dq_out = v.data.half[v.beat];
                v.pins.dq_drive = ~v.pins.we_n;
            end else begin
                v.pins.oe_n = 1'b0;
                v.pins.ub_n = 1'b0;
                v.pins.lb_n = 1'b0;
            end
        end

        rin = v;
    end

    always_ff @(posedge clock) begin
        r <= rin;
        if (reset == 0) begin
            r.state <= state_idle;
            r.ready <= 1'b0;
            r.error <= 1'b0;
            r.pins <= pins_idle;
        end
    end

    assign ctrl_out.mem_ready = r.ready;
    assign ctrl_out.mem_error = r.error;
    assign ctrl_out.mem_rdata = r.data.word;
    assign sram_pins = r.pins;

    // the chip must never be told to drive and take data at once.
    assert property (@(posedge clock) disable iff (reset == 0)
        !(sram_pins.we_n == 1'b0 && sram_pins.oe_n == 1'b0));

endmodule

// ==== design/sram_subsystem.sv ====
module sram_subsystem #(
    parameter int beat_cycles = configure_pkg::beat_cycles
) (
    input logic clock,
    input logic reset,
    input wires_pkg::mem_in_type fetch_in,
    input wires_pkg::mem_in_type data_in,
    output wires_pkg::mem_out_type fetch_out,
    output wires_pkg::mem_out_type data_out,
    output wires_pkg::sram_pins_type sram_pins,
    input logic [configure_pkg::halfword_width-1:0] sram_dq_in
);

    import wires_pkg::*;

    mem_in_type ctrl_in;
    mem_out_type ctrl_out;

    mem_arbiter u_mem_arbiter (
        .clock(clock),
        .reset(reset),
        .fetch_in(fetch_in),
        .data_in(data_in),
        .fetch_out(fetch_out),
        .data_out(data_out),
        .ctrl_in(ctrl_in),
        .ctrl_out(ctrl_out)
    );

    // one controller serves whichever port holds the grant.
    sram_ctrl #(
        .beat_cycles(beat_cycles)
    ) u_sram_ctrl (
        .clock(clock),
        .reset(reset),
        .ctrl_in(ctrl_in),
        .ctrl_out(ctrl_out),
        .sram_pins(sram_pins),
        .sram_dq_in(sram_dq_in)
    );

endmodule

// ==== tests/sram_chip.sv ====
module sram_chip (
    input wires_pkg::sram_pins_type pins,
    output logic [configure_pkg::halfword_width-1:0] dq
);
    timeunit 1ns;
    timeprecision 1ps;

    import configure_pkg::*;
    import wires_pkg::*;

    localparam int depth = 2 ** sram_addr_width;

    logic [halfword_width-1:0] cells [0:depth-1];
    logic [halfword_width-1:0] read_value;
    logic write_enable_n;
    logic chip_drive;

    initial begin
        for (int i = 0; i < depth; i++) begin
            cells[i] = '0;
        end
    end

    assign write_enable_n = pins.we_n;

    // a write lands when we_n rises. the controller still holds address,
    // lanes and its output value at that point.
    always @(posedge write_enable_n) begin
        if (pins.ce_n == 1'b0) begin
            if (pins.ub_n == 1'b0) begin
                cells[pins.addr][15:8] = pins.dq_out[15:8];
            end
            if (pins.lb_n == 1'b0) begin
                cells[pins.addr][7:0] = pins.dq_out[7:0];
            end
        end
    end

    always_comb begin
        read_value = cells[pins.addr];
        if (pins.ub_n == 1'b1) begin
            read_value[15:8] = '1;
        end
        if (pins.lb_n == 1'b1) begin
            read_value[7:0] = '1;
        end
    end

    assign chip_drive = (pins.ce_n == 1'b0) && (pins.oe_n == 1'b0);

    // the bus follows the controller while it drives, the chip while oe_n is low,
    // and floats high otherwise.
    assign dq = pins.dq_drive ? pins.dq_out : (chip_drive ? read_value : '1);

endmodule

// ==== tests/tb_sram_subsystem.sv ====
module tb_sram_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    import configure_pkg::*;
    import wires_pkg::*;

    localparam int field_count = 7;
    localparam int max_ops = 64;
    localparam int clock_period = 10;
    localparam int reset_cycles = 16;
    localparam int timed_latency = 4 * beat_cycles + 2;
    localparam int error_latency = 2;

    logic clock;
    logic reset;
    mem_in_type fetch_in;
    mem_in_type data_in;
    mem_out_type fetch_out;
    mem_out_type data_out;
    sram_pins_type sram_pins;
    logic [halfword_width-1:0] sram_dq_in;

    // columns: mode, port, address, strobes, write data, read data, error.
    logic [63:0] golden [0:field_count*max_ops-1];
    int op_count = 0;
    bit ops_loaded = 1'b0;
    int error_count = 0;
    int check_count = 0;
    int fetch_issued = 0;
    int data_issued = 0;
    int fetch_ready_count = 0;
    int data_ready_count = 0;
    integer seed;

    sram_subsystem u_sram_subsystem (
        .clock(clock),
        .reset(reset),
        .fetch_in(fetch_in),
        .data_in(data_in),
        .fetch_out(fetch_out),
        .data_out(data_out),
        .sram_pins(sram_pins),
        .sram_dq_in(sram_dq_in)
    );

    sram_chip u_sram_chip (
        .pins(sram_pins),
        .dq(sram_dq_in)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    task automatic compare_value(input string what, input logic [63:0] actual,
                                 input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic mem_out_type response_of(input int port);
        if (port == 0) begin
            return fetch_out;
        end
        return data_out;
    endfunction

    task automatic drive_port(input int port, input mem_in_type req);
        if (port == 0) begin
            fetch_in = req;
        end else begin
            data_in = req;
        end
    endtask

    // one golden line: hold the request until ready, then check the answer.
    task automatic run_access(input int index);
        mem_in_type req;
        mem_out_type rsp;
        int port;
        int base;
        int latency;
        bit timed;
        bit pins_touched;
        base = index * field_count;
        timed = (golden[base] == 0);
        port = int'(golden[base + 1]);
        req.mem_valid = 1'b1;
        req.mem_addr = golden[base + 2][31:0];
        req.mem_wstrb = golden[base + 3][7:0];
        req.mem_wdata = golden[base + 4];
        rsp = '0;
        latency = 0;
        pins_touched = 1'b0;
        @(negedge clock);
        drive_port(port, req);
        if (port == 0) begin
            fetch_issued++;
        end else begin
            data_issued++;
        end
        while (rsp.mem_ready == 1'b0) begin
            @(negedge clock);
            rsp = response_of(port);
            if (sram_pins.ce_n == 1'b0) begin
                pins_touched = 1'b1;
            end
            if (rsp.mem_ready == 1'b0) begin
                latency++;
            end
        end
        drive_port(port, '0);
        compare_value($sformatf("op %0d mem_error", index), 64'(rsp.mem_error), golden[base + 6]);
        if (req.mem_wstrb == '0 && golden[base + 6] == 0) begin
            compare_value($sformatf("op %0d mem_rdata", index), rsp.mem_rdata, golden[base + 5]);
        end
        if (timed && golden[base + 6] != 0) begin
            compare_value($sformatf("op %0d error latency", index), 64'(latency),
                          64'(error_latency));
            compare_value($sformatf("op %0d pin activity", index), 64'(pins_touched), 64'd0);
        end else if (timed) begin
            compare_value($sformatf("op %0d latency", index), 64'(latency), 64'(timed_latency));
        end
    endtask

    // every ready pulse lasts one cycle, so each request adds exactly one.
    always @(negedge clock) begin
        if (reset == 1'b1) begin
            if (fetch_out.mem_ready) begin
                fetch_ready_count++;
            end
            if (data_out.mem_ready) begin
                data_ready_count++;
            end
        end
    end

    initial begin
        int index;
        int gap;
        seed = 63;
        reset = 1'b0;
        fetch_in = '0;
        data_in = '0;
        for (int i = 0; i < field_count * max_ops; i++) begin
            golden[i] = '1;
        end
        $readmemh("tests/sram_golden.hex", golden);
        while (op_count < max_ops && golden[op_count * field_count] !== '1) begin
            op_count++;
        end
        ops_loaded = 1'b1;
        if (op_count == 0) begin
            error_count++;
            $display("Error: no operations could be read from tests/sram_golden.hex");
        end

        repeat (reset_cycles) @(negedge clock);
        reset = 1'b1;

        @(negedge clock);
        compare_value("fetch mem_ready after reset", 64'(fetch_out.mem_ready), 64'd0);
        compare_value("data mem_ready after reset", 64'(data_out.mem_ready), 64'd0);
        compare_value("control pins after reset", 64'({sram_pins.ce_n, sram_pins.we_n,
                      sram_pins.oe_n, sram_pins.ub_n, sram_pins.lb_n}), 64'h1f);
        compare_value("dq_drive after reset", 64'(sram_pins.dq_drive), 64'd0);

        index = 0;
        while (index < op_count) begin
            // mode 1 starts both ports in the same cycle.
            if (golden[index * field_count] == 1 && index + 1 < op_count) begin
                fork
                    run_access(index);
                    run_access(index + 1);
                join
                index += 2;
            end else begin
                run_access(index);
                index += 1;
            end
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clock);
        end

        repeat (4) @(negedge clock);
        compare_value("fetch ready pulses", 64'(fetch_ready_count), 64'(fetch_issued));
        compare_value("data ready pulses", 64'(data_ready_count), 64'(data_issued));

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        int limit_ns;
        wait (ops_loaded);
        limit_ns = op_count * (2 * timed_latency + 3) * clock_period
                   + reset_cycles * clock_period;
        #(limit_ns);
        $display("Error: the run timed out after %0d ns with an access still open", limit_ns);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== tests/sram_golden.hex ====
// mode port addr strb wdata rdata error, all hex. port 0 is fetch, 1 is data.
// mode 0 is an isolated timed access, mode 1 runs with the next line in the same cycle.
0 1 00000000 ff 0123456789abcdef 0 0
0 0 00000000 00 0 0123456789abcdef 0
0 1 00000008 ff 1122334455667788 0 0
0 1 00000008 0f aaaaaaaaaaaaaaaa 0 0
0 1 00000008 00 0 11223344aaaaaaaa 0
0 1 00000008 a5 f0e0d0c0b0a09080 0 0
0 0 00000008 00 0 f022d044aaa0aa80 0
0 1 0007fff8 ff deadbeefcafef00d 0 0
0 1 0007fff8 00 0 deadbeefcafef00d 0
0 1 00080000 ff 5555555555555555 0 1
0 1 fffffff8 ff 5a5a5a5a5a5a5a5a 0 1
0 0 00080008 00 0 0 1
0 1 00000000 00 0 0123456789abcdef 0
0 0 0007fff8 00 0 deadbeefcafef00d 0
1 0 00000000 00 0 0123456789abcdef 0
1 1 00000008 00 0 f022d044aaa0aa80 0
1 0 0007fff8 00 0 deadbeefcafef00d 0
1 1 00000010 ff 0f1e2d3c4b5a6978 0 0
0 0 00000010 00 0 0f1e2d3c4b5a6978 0
1 0 00100000 00 0 0 1
1 1 00000018 ff 7766554433221100 0 0
0 1 00000018 00 0 7766554433221100 0
0 1 00012340 ff 8899aabbccddeeff 0 0
0 1 00012340 3c 0000000000000000 0 0
0 0 00012340 00 0 889900000000eeff 0

// ==== tb.f ====
design/configure_pkg.sv
design/wires_pkg.sv
design/mem_arbiter.sv
design/sram_ctrl.sv
design/sram_subsystem.sv
tests/sram_chip.sv
tests/tb_sram_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f tb.f \
        --top-module tb_sram_subsystem -o tb_sram_subsystem; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sram_subsystem)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
